/* hdl/xbus_pkg.sv */
// Link word format for the serial link side of the bridge
// Every word is a 4-bit tag on top of a 32-bit payload, one word per clock
// Tag values follow the existing link encoding and must not be renumbered
`default_nettype none

package xbus_pkg;

  // ==========================================================================
  // Word layout
  // ==========================================================================

  localparam int XB_W  = 36;
  localparam int TAG_W = 4;
  localparam int PAY_W = 32;

  // Number of 32-bit payload lanes in one bus word
  localparam int LANES = 4;

  // ==========================================================================
  // Tags
  // ==========================================================================

  // NOP marks an idle link cycle in both directions
  localparam logic [TAG_W-1:0] TAG_NOP  = 4'd0;
  localparam logic [TAG_W-1:0] TAG_ADDR = 4'd1;
  localparam logic [TAG_W-1:0] TAG_CMD  = 4'd3;

  // Data tags run in lane order, so lane n uses TAG_D0 + n
  localparam logic [TAG_W-1:0] TAG_D0 = 4'd4;
  localparam logic [TAG_W-1:0] TAG_D1 = 4'd5;
  localparam logic [TAG_W-1:0] TAG_D2 = 4'd6;
  localparam logic [TAG_W-1:0] TAG_D3 = 4'd7;

  // ==========================================================================
  // Command payload fields
  // ==========================================================================

  localparam int CMD_WE_BIT    = 31;
  localparam int CMD_START_BIT = 28;

  // Both completion flags in bits 30:29 are set on the return path
  localparam logic [PAY_W-1:0] CMD_DONE_BITS = 32'h6000_0000;

endpackage

`default_nettype wire

/* hdl/sysbus_pkg.sv */
// On-chip bus widths and the request and response records between stages
// The select mask carries one bit per byte of the 128-bit data word
`default_nettype none

package sysbus_pkg;

  localparam int ADR_W = 32;
  localparam int DAT_W = 128;
  localparam int SEL_W = 16;

  // One bus request as assembled from the link words
  typedef struct packed {
    logic             we;
    logic [SEL_W-1:0] sel;
    logic [ADR_W-1:0] adr;
    logic [DAT_W-1:0] dat;
  } sysbus_req_t;

  // One finished bus cycle, with the flag and mask that shape the reply
  typedef struct packed {
    logic             we;
    logic [SEL_W-1:0] sel;
    logic [DAT_W-1:0] dat;
  } sysbus_rsp_t;

endpackage

`default_nettype wire

/* hdl/sysbus_if.sv */
// Classic single-cycle-ack bus between the bridge and its target
// No stall or error signalling; a target must always ack eventually
`timescale 1ns/1ps
`default_nettype none

interface sysbus_if;

  logic                        cyc;
  logic                        stb;
  logic                        we;
  logic [sysbus_pkg::SEL_W-1:0] sel;
  logic [sysbus_pkg::ADR_W-1:0] adr;
  logic [sysbus_pkg::DAT_W-1:0] dat_w;
  logic [sysbus_pkg::DAT_W-1:0] dat_r;
  logic                        ack;

  // The master owns the cycle and the write side
  modport master (
    output cyc, stb, we, sel, adr, dat_w,
    input  dat_r, ack
  );

  // The target answers with read data and one ack pulse
  modport target (
    input  cyc, stb, we, sel, adr, dat_w,
    output dat_r, ack
  );

endinterface

`default_nettype wire

/* hdl/xbus_rx_decoder.sv */
// Collects address, data and command words from the link into one request
// Data and address registers keep their value, so a repeat command reuses them
// Only one transaction may be open; the sender waits for the completion word
`timescale 1ns/1ps
`default_nettype none

module xbus_rx_decoder (
  input  wire logic                      clk_i,
  input  wire logic                      rst_i,
  input  wire logic [xbus_pkg::XB_W-1:0] xb_dat_i,
  input  wire logic                      busy_i,
  output logic                           req_stb_o,
  output sysbus_pkg::sysbus_req_t        req_o
);

  logic [xbus_pkg::TAG_W-1:0] tag;
  logic [xbus_pkg::PAY_W-1:0] pay;
  logic [1:0]                 lane;
  logic                       start;

  // Split the link word into its tag and payload
  assign tag   = xb_dat_i[xbus_pkg::XB_W-1 -: xbus_pkg::TAG_W];
  assign pay   = xb_dat_i[xbus_pkg::PAY_W-1:0];
  assign lane  = 2'(tag - xbus_pkg::TAG_D0);
  assign start = (tag == xbus_pkg::TAG_CMD) && pay[xbus_pkg::CMD_START_BIT];

  // ==========================================================================
  // Request fields, loaded by tag
  // ==========================================================================

  always_ff @(posedge clk_i) begin
    case (tag)
      xbus_pkg::TAG_ADDR: begin
        req_o.adr <= pay;
      end
      xbus_pkg::TAG_CMD: begin
        req_o.we  <= pay[xbus_pkg::CMD_WE_BIT];
        req_o.sel <= pay[sysbus_pkg::SEL_W-1:0];
      end
      xbus_pkg::TAG_D0, xbus_pkg::TAG_D1, xbus_pkg::TAG_D2, xbus_pkg::TAG_D3: begin
        // Data tags map straight onto the 32-bit lanes, D0 lowest
        req_o.dat[lane*xbus_pkg::PAY_W +: xbus_pkg::PAY_W] <= pay;
      end
      default: begin
        // NOP and unknown tags leave the request untouched
      end
    endcase
  end

  // One strobe per start command, in the cycle right after the command
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_stb_o <= 1'b0;
    end else begin
      req_stb_o <= start;
    end
  end

  // A start command is only legal once the previous completion has been sent
  // and no request is still on its way to the bus master
  a_no_start_when_busy : assert property (
    @(posedge clk_i) disable iff (rst_i)
    start |-> !(busy_i || req_stb_o)
  );

endmodule

`default_nettype wire

/* hdl/xbus_bus_master.sv */
// Runs one bus cycle per request and hands the result to the serializer
// The cycle has no timeout; a target that never acks hangs the bridge
`timescale 1ns/1ps
`default_nettype none

module xbus_bus_master (
  input  wire logic                           clk_i,
  input  wire logic                           rst_i,
  input  wire logic                           req_stb_i,
  input  wire sysbus_pkg::sysbus_req_t        req_i,
  sysbus_if.master                            bus,
  input  wire logic                           done_i,
  output logic                                busy_o,
  output logic                                rsp_stb_o,
  output sysbus_pkg::sysbus_rsp_t             rsp_o
);

  logic ack_seen;

  assign ack_seen = bus.cyc && bus.stb && bus.ack;

  // ==========================================================================
  // Cycle control
  // ==========================================================================

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bus.cyc   <= 1'b0;
      bus.stb   <= 1'b0;
      busy_o    <= 1'b0;
      rsp_stb_o <= 1'b0;
    end else begin
      rsp_stb_o <= ack_seen;
      if (req_stb_i) begin
        bus.cyc <= 1'b1;
        bus.stb <= 1'b1;
        busy_o  <= 1'b1;
      end else if (ack_seen) begin
        // The ack ends the cycle on this same edge
        bus.cyc <= 1'b0;
        bus.stb <= 1'b0;
      end
      // Busy covers the whole reply, up to the completion word
      if (done_i) begin
        busy_o <= 1'b0;
      end
    end
  end

  // Address, mask and write data are launched with the cycle and then held
  always_ff @(posedge clk_i) begin
    if (req_stb_i) begin
      bus.we    <= req_i.we;
      bus.sel   <= req_i.sel;
      bus.adr   <= req_i.adr;
      bus.dat_w <= req_i.dat;
    end
  end

  // Read data is taken at the ack, along with what the reply needs to know
  always_ff @(posedge clk_i) begin
    if (ack_seen) begin
      rsp_o.we  <= bus.we;
      rsp_o.sel <= bus.sel;
      rsp_o.dat <= bus.dat_r;
    end
  end

  // Nothing on the bus may move until the target has acked
  a_bus_stable : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (bus.cyc && bus.stb && !bus.ack) |=>
      (bus.cyc && bus.stb && $stable({bus.we, bus.sel, bus.adr, bus.dat_w}))
  );

  // The target must not ack outside of an open cycle
  a_ack_in_cycle : assert property (
    @(posedge clk_i) disable iff (rst_i)
    bus.ack |-> bus.cyc
  );

endmodule

`default_nettype wire

/* hdl/xbus_resp_serializer.sv */
// Sends the reply to one bus cycle back over the link, one word per clock
// Reads return each lane with a non-zero select nibble, lowest lane first
// Every reply ends with a single completion word; idle cycles carry NOP
`timescale 1ns/1ps
`default_nettype none

module xbus_resp_serializer (
  input  wire logic                    clk_i,
  input  wire logic                    rst_i,
  input  wire logic                    rsp_stb_i,
  input  wire sysbus_pkg::sysbus_rsp_t rsp_i,
  output logic [xbus_pkg::XB_W-1:0]    xb_dat_o,
  output logic                         done_o
);

  localparam int LANE_IW = $clog2(xbus_pkg::LANES);
  localparam int NIB_W   = sysbus_pkg::SEL_W / xbus_pkg::LANES;

  typedef enum logic {
    ST_IDLE,
    ST_SEND
  } state_t;

  state_t                         state_q;
  logic [xbus_pkg::LANES-1:0]     pend_q;
  logic [xbus_pkg::LANES-1:0]     rsp_lanes;
  logic [xbus_pkg::LANES-1:0]     cur_pend;
  logic [sysbus_pkg::DAT_W-1:0]   dat_q;
  logic [sysbus_pkg::DAT_W-1:0]   cur_dat;
  logic                           active;
  logic                           lane_hit;
  logic [LANE_IW-1:0]             lane_idx;

  // A lane is sent back only on a read, and only if any of its bytes was selected
  always_comb begin
    for (int i = 0; i < xbus_pkg::LANES; i++) begin
      rsp_lanes[i] = !rsp_i.we && (|rsp_i.sel[i*NIB_W +: NIB_W]);
    end
  end

  // In idle the reply starts straight from the strobe, so no cycle is lost
  assign active   = (state_q == ST_SEND) || rsp_stb_i;
  assign cur_pend = (state_q == ST_IDLE) ? rsp_lanes : pend_q;
  assign cur_dat  = (state_q == ST_IDLE) ? rsp_i.dat : dat_q;

  // Pick the lowest pending lane
  always_comb begin
    lane_hit = 1'b0;
    lane_idx = '0;
    for (int i = xbus_pkg::LANES - 1; i >= 0; i--) begin
      if (cur_pend[i]) begin
        lane_hit = 1'b1;
        lane_idx = LANE_IW'(i);
      end
    end
  end

  // ==========================================================================
  // Output word sequencer
  // ==========================================================================

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= ST_IDLE;
      pend_q   <= '0;
      done_o   <= 1'b0;
      xb_dat_o <= {xbus_pkg::TAG_NOP, {xbus_pkg::PAY_W{1'b0}}};
    end else begin
      done_o   <= 1'b0;
      xb_dat_o <= {xbus_pkg::TAG_NOP, {xbus_pkg::PAY_W{1'b0}}};
      if (active) begin
        if (lane_hit) begin
          // Data tag follows the lane number
          xb_dat_o <= {xbus_pkg::TAG_D0 + xbus_pkg::TAG_W'(lane_idx),
                       cur_dat[lane_idx*xbus_pkg::PAY_W +: xbus_pkg::PAY_W]};
          pend_q   <= cur_pend & ~(xbus_pkg::LANES'(1) << lane_idx);
          state_q  <= ST_SEND;
        end else begin
          // All lanes out, so close the transaction
          xb_dat_o <= {xbus_pkg::TAG_CMD, xbus_pkg::CMD_DONE_BITS};
          done_o   <= 1'b1;
          state_q  <= ST_IDLE;
        end
      end
    end
  end

  // Read data is held for the lanes that follow the first one
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && rsp_stb_i) begin
      dat_q <= rsp_i.dat;
    end
  end

endmodule

`default_nettype wire

/* hdl/lane_memory.sv */
// Bus target with 2**MEM_AW lines of 128 bits, written per byte lane
// MEM_WAIT must be 1 or more; address bits above the line index are ignored
// Contents are not cleared by reset
`timescale 1ns/1ps
`default_nettype none

module lane_memory #(
  parameter int MEM_AW   = 6,
  parameter int MEM_WAIT = 2
) (
  input  wire logic clk_i,
  input  wire logic rst_i,
  sysbus_if.target  bus
);

  localparam int CW = (MEM_WAIT > 1) ? $clog2(MEM_WAIT) : 1;

  logic [sysbus_pkg::DAT_W-1:0] mem_q [2**MEM_AW];
  logic [CW-1:0]                wait_cnt;
  logic [MEM_AW-1:0]            line;
  logic                         last_wait;
  logic                         hit;

  // Lines are 16 bytes, so the index starts at address bit 4
  assign line      = bus.adr[4 +: MEM_AW];
  assign last_wait = (wait_cnt == CW'(MEM_WAIT - 1));
  assign hit       = bus.cyc && bus.stb && !bus.ack && last_wait;

  // Wait counter and the ack pulse
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bus.ack  <= 1'b0;
      wait_cnt <= '0;
    end else if (bus.ack) begin
      bus.ack  <= 1'b0;
      wait_cnt <= '0;
    end else if (bus.cyc && bus.stb) begin
      if (last_wait) begin
        bus.ack <= 1'b1;
      end else begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end
  end

  // Write commit and read data both land on the edge that raises ack
  always_ff @(posedge clk_i) begin
    if (hit) begin
      bus.dat_r <= mem_q[line];
      for (int b = 0; b < sysbus_pkg::SEL_W; b++) begin
        if (bus.we && bus.sel[b]) begin
          mem_q[line][b*8 +: 8] <= bus.dat_w[b*8 +: 8];
        end
      end
    end
  end

  // The ack comes MEM_WAIT cycles into an open cycle and lasts one cycle
  a_ack_single : assert property (
    @(posedge clk_i) disable iff (rst_i)
    $rose(bus.cyc && bus.stb) |-> ##MEM_WAIT bus.ack ##1 !bus.ack
  );

endmodule

`default_nettype wire

/* hdl/xbus_slave_bridge_top.sv */
// Link-to-bus bridge with a local lane memory as the bus target
// Single clock; one transaction at a time, with no back-pressure on the link
`timescale 1ns/1ps
`default_nettype none

module xbus_slave_bridge_top #(
  parameter int MEM_AW   = 6,
  parameter int MEM_WAIT = 2
) (
  input  wire logic                      clk_i,
  input  wire logic                      rst_i,
  input  wire logic [xbus_pkg::XB_W-1:0] xb_dat_i,
  output wire logic [xbus_pkg::XB_W-1:0] xb_dat_o
);

  logic                    req_stb;
  sysbus_pkg::sysbus_req_t req;
  logic                    busy;
  logic                    rsp_stb;
  sysbus_pkg::sysbus_rsp_t rsp;
  logic                    done;

  sysbus_if bus_if ();

  // Link words in, one request out
  xbus_rx_decoder u_decoder (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .xb_dat_i  (xb_dat_i),
    .busy_i    (busy),
    .req_stb_o (req_stb),
    .req_o     (req)
  );

  xbus_bus_master u_master (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .req_stb_i (req_stb),
    .req_i     (req),
    .bus       (bus_if.master),
    .done_i    (done),
    .busy_o    (busy),
    .rsp_stb_o (rsp_stb),
    .rsp_o     (rsp)
  );

  // Reply words back onto the link
  xbus_resp_serializer u_serializer (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .rsp_stb_i (rsp_stb),
    .rsp_i     (rsp),
    .xb_dat_o  (xb_dat_o),
    .done_o    (done)
  );

  lane_memory #(
    .MEM_AW   (MEM_AW),
    .MEM_WAIT (MEM_WAIT)
  ) u_memory (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .bus   (bus_if.target)
  );

endmodule

`default_nettype wire

/* tb/tb_xbus_bridge.sv */
// Table-driven testbench for the link-to-bus bridge with a byte-level memory model
// Every memory line is written through the bridge first, so all later reads are defined
// Stops at the first wrong word; each reply wait has its own cycle limit
`timescale 1ns/1ps
`default_nettype none

module tb_xbus_bridge;

  localparam int MEM_AW   = 6;
  localparam int MEM_WAIT = 3;
  localparam int N_FIXED  = 8;
  localparam int N_ROWS   = 24;
  localparam int WAIT_MAX = 64;

  // Byte addresses that fall inside the memory, 16 bytes per line
  localparam logic [31:0] ADR_MASK = 32'((2**MEM_AW) * 16 - 1);

  logic                      clk_i;
  logic                      rst_i;
  logic [xbus_pkg::XB_W-1:0] xb_dat_i;
  logic [xbus_pkg::XB_W-1:0] xb_dat_o;

  // Transaction table, one row per bus cycle
  logic         row_we  [N_ROWS];
  logic [31:0]  row_adr [N_ROWS];
  logic [15:0]  row_sel [N_ROWS];
  logic [127:0] row_dat [N_ROWS];

  logic [127:0] ref_mem [2**MEM_AW];
  logic [35:0]  exp_q [$];
  integer       seed;

  xbus_slave_bridge_top #(
    .MEM_AW   (MEM_AW),
    .MEM_WAIT (MEM_WAIT)
  ) dut_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .xb_dat_i (xb_dat_i),
    .xb_dat_o (xb_dat_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // ==========================================================================
  // Error reporting and checks
  // ==========================================================================

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("Regression failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_word(input logic [35:0] got, input logic [35:0] exp,
                            input string where, input int idx);
    assert (got === exp) else
      stop_with_error($sformatf("Mismatch at %0t ns: %s word %0d got %09h expected %09h",
                                $time, where, idx, got, exp));
  endtask

  // ==========================================================================
  // Memory model and link traffic
  // ==========================================================================

  // Updates the model for a write, or lists the reply words of a read
  task automatic predict_reply(input logic we, input logic [31:0] adr,
                               input logic [15:0] sel, input logic [127:0] dat);
    logic [MEM_AW-1:0] line;
    logic [3:0]        tag;
    line = adr[4 +: MEM_AW];
    exp_q.delete();
    if (we) begin
      for (int b = 0; b < 16; b++) begin
        if (sel[b]) ref_mem[line][b*8 +: 8] = dat[b*8 +: 8];
      end
    end else begin
      // A lane comes back whole when any of its four bytes is selected
      for (int l = 0; l < 4; l++) begin
        if (sel[l*4 +: 4] != 4'h0) begin
          tag = xbus_pkg::TAG_D0 + 4'(l);
          exp_q.push_back({tag, ref_mem[line][l*32 +: 32]});
        end
      end
    end
    // Completion word has only bits 30:29 set
    exp_q.push_back({xbus_pkg::TAG_CMD, 32'h6000_0000});
  endtask

  task automatic send_word(input logic [3:0] tag, input logic [31:0] pay);
    @(posedge clk_i);
    xb_dat_i <= {tag, pay};
  endtask

  // Idle NOP words may come first, then the reply must run back to back
  task automatic collect_reply(input string where);
    int waited;
    int idx;
    waited = 0;
    idx = 0;
    while (idx < exp_q.size()) begin
      @(negedge clk_i);
      if (idx == 0 && xb_dat_o === 36'h0) begin
        waited++;
        if (waited > WAIT_MAX) begin
          stop_with_error($sformatf("No reply to %s within %0d cycles", where, WAIT_MAX));
        end
      end else begin
        check_word(xb_dat_o, exp_q[idx], where, idx);
        idx++;
      end
    end
    // The link is back to NOP right after the completion word
    @(negedge clk_i);
    check_word(xb_dat_o, 36'h0, where, idx);
  endtask

  task automatic run_transaction(input logic we, input logic [31:0] adr,
                                 input logic [15:0] sel, input logic [127:0] dat,
                                 input string where);
    logic [3:0] tag;
    predict_reply(we, adr, sel, dat);
    send_word(xbus_pkg::TAG_ADDR, adr);
    for (int l = 0; l < 4; l++) begin
      tag = xbus_pkg::TAG_D0 + 4'(l);
      send_word(tag, dat[l*32 +: 32]);
    end
    // Command word with the write flag at 31, start at 28 and the select mask in 15:0
    send_word(xbus_pkg::TAG_CMD, {we, 2'b00, 1'b1, 12'h000, sel});
    send_word(xbus_pkg::TAG_NOP, 32'h0);
    collect_reply(where);
  endtask

  // ==========================================================================
  // Table
  // ==========================================================================

  task automatic set_row(input int r, input logic we, input logic [31:0] adr,
                         input logic [15:0] sel, input logic [127:0] dat);
    row_we[r]  = we;
    row_adr[r] = adr;
    row_sel[r] = sel;
    row_dat[r] = dat;
  endtask

  task automatic build_table();
    // Full write and full read back on one line
    set_row(0, 1'b1, 32'h120, 16'hffff, 128'hd3d3_0003_c2c2_0002_b1b1_0001_a0a0_0000);
    set_row(1, 1'b0, 32'h120, 16'hffff, '0);
    // Partial masks return lanes 0 and 2, then lane 3 alone
    set_row(2, 1'b0, 32'h124, 16'h0f0f, '0);
    set_row(3, 1'b0, 32'h12c, 16'hf000, '0);
    // One byte per lane is merged into the line
    set_row(4, 1'b1, 32'h120, 16'h8421, 128'hffee_ddcc_bbaa_9988_7766_5544_3322_1144);
    set_row(5, 1'b0, 32'h120, 16'hffff, '0);
    // Empty mask read gives the completion word alone
    set_row(6, 1'b0, 32'h3f0, 16'h0000, '0);
    set_row(7, 1'b0, 32'h3f8, 16'h0010, '0);
    for (int r = N_FIXED; r < N_ROWS; r++) begin
      row_we[r]  = 1'($random(seed));
      row_adr[r] = $random(seed) & ADR_MASK;
      row_sel[r] = 16'($random(seed));
      if (r % 4 == 0) row_sel[r] = 16'hffff;
      if (r % 7 == 0) row_sel[r] = 16'h0000;
      row_dat[r] = {$random(seed), $random(seed), $random(seed), $random(seed)};
    end
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================

  initial begin
    seed     = 12;
    rst_i    = 1'b1;
    xb_dat_i = '0;
    build_table();
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    for (int i = 0; i < 3; i++) begin
      @(negedge clk_i);
      check_word(xb_dat_o, 36'h0, "idle after reset", i);
    end
    // Fill every line so that the model and the memory start out equal
    for (int l = 0; l < 2**MEM_AW; l++) begin
      run_transaction(1'b1, 32'(l * 16), 16'hffff,
                      {$random(seed), $random(seed), $random(seed), $random(seed)},
                      $sformatf("fill line %0d", l));
    end
    for (int r = 0; r < N_ROWS; r++) begin
      run_transaction(row_we[r], row_adr[r], row_sel[r], row_dat[r],
                      $sformatf("row %0d", r));
    end
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
hdl/xbus_pkg.sv
hdl/sysbus_pkg.sv
hdl/sysbus_if.sv
hdl/xbus_rx_decoder.sv
hdl/xbus_bus_master.sv
hdl/xbus_resp_serializer.sv
hdl/lane_memory.sv
hdl/xbus_slave_bridge_top.sv
tb/tb_xbus_bridge.sv

/* Makefile */
TB_TOP := tb_xbus_bridge

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f src.f --top-module xbus_slave_bridge_top

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TB_TOP) -o sim_tb
	out=$$(./obj_dir/sim_tb 2>&1); echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
